// File: vlog.f
hdl/zcmp_pkg.sv
hdl/zcmp_decode.sv
hdl/zcmp_sequencer.sv
hdl/zcmp_result.sv
hdl/zcmp_expander.sv
dv/zcmp_expander_asserts.sv
dv/tb_zcmp_expander.sv

// File: Bender.yml
package:
  name: zcmp_expander

sources:
  # rtl in compile order
  - files:
      - hdl/zcmp_pkg.sv
      - hdl/zcmp_decode.sv
      - hdl/zcmp_sequencer.sv
      - hdl/zcmp_result.sv
      - hdl/zcmp_expander.sv

  # testbench and bound assertions
  - target: test
    files:
      - dv/zcmp_expander_asserts.sv
      - dv/tb_zcmp_expander.sv

// File: dv/tb_zcmp_expander.sv
// testbench for the zcmp expander, lfsr stimulus checked against a reference model
`timescale 1ns/1ps

module tb_zcmp_expander;
  import zcmp_pkg::*;

  localparam int unsigned NUM_PARCELS    = 300;
  localparam int unsigned SWEEP_PARCELS  = 48;  // push with rlist 4..15 and spimm 0..3
  localparam int unsigned TIMEOUT_CYCLES = NUM_PARCELS * 16 * 4 + 200;
  localparam logic [31:0] LFSR_SEED      = 32'h11c0d03a;
  localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

  logic        clk_i;
  logic        rst_ni;
  logic [15:0] parcel_i;
  logic        parcel_valid_i;
  logic        parcel_ready_o;
  logic        issue_ack_i;
  logic [31:0] instr_o;
  logic        instr_valid_o;
  logic        illegal_o;
  logic        fetch_stall_o;

  logic [31:0] lfsr_q;
  logic [33:0] exp_q[$];  // {last, illegal, word}
  int unsigned checks;
  int unsigned value_errs;
  int unsigned other_errs;
  int unsigned cycles;
  logic        taken;

  zcmp_expander DUT (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  function automatic logic [15:0] rand_bits(input int unsigned n);
    logic [15:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic int reg_count(input logic [3:0] rlist);
    return (rlist == 4'd15) ? 13 : int'(rlist) - 3;
  endfunction

  function automatic logic [4:0] list_reg(input int idx);
    if (idx == 0) return 5'd1;
    if (idx < 3) return 5'(idx + 7);  // s0, s1
    return 5'(idx + 15);              // s2 = x18
  endfunction

  function automatic int adj_bytes(input int n, input int spimm);
    return ((n * 4 + 15) / 16) * 16 + spimm * 16;
  endfunction

  function automatic logic [4:0] move_reg(input logic [2:0] f);
    return (f < 3'd2) ? 5'(8 + f) : 5'(16 + f);
  endfunction

  function automatic logic [31:0] s_word(input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, REG_SP, FUNCT3_W, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  task automatic expect_word(input logic [31:0] w, input logic ill, input logic last);
    exp_q.push_back({last, ill, w});
  endtask

  // reference expansion of one accepted parcel
  task automatic expand_parcel(input logic [15:0] p);
    zcmp_op_e op;
    int       n;
    int       adj;
    op  = OP_ILLEGAL;
    n   = reg_count(p[7:4]);
    adj = adj_bytes(n, int'(p[3:2]));
    if (p[1:0] == 2'b10 && p[15:13] == 3'b101) begin
      if (p[12:10] == 3'b011) begin
        if (p[9:7] != p[4:2] && p[6:5] == 2'b01) op = OP_MVSA01;
        if (p[9:7] != p[4:2] && p[6:5] == 2'b11) op = OP_MVA01S;
      end else if (p[7:4] >= 4'd4) begin
        case (p[12:8])
          5'b11000: op = OP_PUSH;
          5'b11010: op = OP_POP;
          5'b11100: op = OP_POPRETZ;
          5'b11110: op = OP_POPRET;
          default:  op = OP_ILLEGAL;
        endcase
      end
    end
    case (op)
      OP_PUSH: begin
        for (int k = 1; k <= n; k++) begin
          expect_word(s_word(list_reg(n - k), 12'(0 - 4 * k)), 1'b0, 1'b0);
        end
        expect_word(i_word(OPC_OP_IMM, 3'b000, REG_SP, REG_SP, 12'(0 - adj)), 1'b0, 1'b1);
      end
      OP_POP, OP_POPRETZ, OP_POPRET: begin
        for (int k = 1; k <= n; k++) begin
          expect_word(i_word(OPC_LOAD, 3'b010, list_reg(n - k), REG_SP, 12'(adj - 4 * k)),
                      1'b0, 1'b0);
        end
        if (op == OP_POPRETZ) begin
          expect_word(i_word(OPC_OP_IMM, 3'b000, REG_A0, REG_ZERO, 12'd0), 1'b0, 1'b0);
        end
        expect_word(i_word(OPC_OP_IMM, 3'b000, REG_SP, REG_SP, 12'(adj)), 1'b0, op == OP_POP);
        if (op != OP_POP) begin
          expect_word(i_word(OPC_JALR, 3'b000, REG_ZERO, REG_RA, 12'd0), 1'b0, 1'b1);
        end
      end
      OP_MVSA01: begin
        expect_word(i_word(OPC_OP_IMM, 3'b000, move_reg(p[9:7]), REG_A0, 12'd0), 1'b0, 1'b0);
        expect_word(i_word(OPC_OP_IMM, 3'b000, move_reg(p[4:2]), REG_A1, 12'd0), 1'b0, 1'b1);
      end
      OP_MVA01S: begin
        expect_word(i_word(OPC_OP_IMM, 3'b000, REG_A0, move_reg(p[9:7]), 12'd0), 1'b0, 1'b0);
        expect_word(i_word(OPC_OP_IMM, 3'b000, REG_A1, move_reg(p[4:2]), 12'd0), 1'b0, 1'b1);
      end
      default: expect_word({16'h0000, p}, 1'b1, 1'b1);
    endcase
  endtask

  // all push forms first and then a random mix
  function automatic logic [15:0] next_parcel(input int unsigned idx);
    logic [2:0]  cat;
    logic [3:0]  rlist;
    logic [1:0]  spimm;
    logic [2:0]  r1f;
    logic [2:0]  r2f;
    logic [1:0]  mv;
    logic [10:0] fn_bits;
    if (idx < SWEEP_PARCELS) begin
      return {3'b101, 5'b11000, 4'(4 + idx / 4), 2'(idx % 4), 2'b10};
    end
    cat   = 3'(rand_bits(3));
    rlist = 4'(rand_bits(4));  // reserved values show up now and then
    spimm = 2'(rand_bits(2));
    case (cat)
      3'd0, 3'd1: return {3'b101, 5'b11000, rlist, spimm, 2'b10};
      3'd2:       return {3'b101, 5'b11010, rlist, spimm, 2'b10};
      3'd3:       return {3'b101, 5'b11100, rlist, spimm, 2'b10};
      3'd4:       return {3'b101, 5'b11110, rlist, spimm, 2'b10};
      3'd5: begin
        r1f = 3'(rand_bits(3));
        mv  = rand_bits(1) ? 2'b11 : 2'b01;
        r2f = 3'(rand_bits(3));
        return {3'b101, 3'b011, r1f, mv, r2f, 2'b10};
      end
      3'd6: begin
        fn_bits = 11'(rand_bits(11));
        return {3'b101, fn_bits, 2'b10};
      end
      default:    return rand_bits(16);
    endcase
  endfunction

  // outputs and handshakes are sampled mid-cycle
  always @(negedge clk_i) begin : monitor
    logic [33:0] exp;
    if (rst_ni) begin
      if (instr_valid_o && issue_ack_i) begin
        assert (exp_q.size() != 0) else begin
          other_errs++;
          $display("unexpected instruction %h issued at %0t", instr_o, $time);
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          checks++;
          assert (instr_o == exp[31:0]) else begin
            value_errs++;
            $display("Fail %0t: instr expected %h got %h", $time, exp[31:0], instr_o);
          end
          assert (illegal_o == exp[32]) else begin
            value_errs++;
            $display("Fail %0t: illegal expected %b got %b", $time, exp[32], illegal_o);
          end
          assert (fetch_stall_o == !exp[33]) else begin
            value_errs++;
            $display("Fail %0t: stall expected %b got %b", $time, !exp[33], fetch_stall_o);
          end
        end
      end
      if (parcel_valid_i && parcel_ready_o) begin
        expand_parcel(parcel_i);
        taken = 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d words still expected", cycles, exp_q.size());
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    int unsigned sent;
    logic        holding;
    sent           = 0;
    holding        = 1'b0;
    taken          = 1'b0;
    checks         = 0;
    value_errs     = 0;
    other_errs     = 0;
    cycles         = 0;
    lfsr_q         = LFSR_SEED;
    rst_ni         = 1'b0;
    parcel_i       = '0;
    parcel_valid_i = 1'b0;
    issue_ack_i    = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!instr_valid_o && !illegal_o && !fetch_stall_o && parcel_ready_o) else begin
      other_errs++;
      $display("outputs not in their idle state after reset");
    end

    while (sent < NUM_PARCELS || exp_q.size() != 0) begin
      @(posedge clk_i);
      #2;
      if (taken) begin
        taken          = 1'b0;
        holding        = 1'b0;
        parcel_valid_i = 1'b0;
        sent++;
      end
      issue_ack_i = (rand_bits(4) < 11);  // roughly 70 percent
      if (!holding && sent < NUM_PARCELS) begin
        if (rand_bits(2) == 2'd0) begin
          parcel_valid_i = 1'b0;  // idle gap
        end else begin
          parcel_i       = next_parcel(sent);
          parcel_valid_i = 1'b1;
          holding        = 1'b1;
        end
      end
    end

    repeat (4) @(posedge clk_i);
    assert (!instr_valid_o) else begin
      other_errs++;
      $display("instruction still valid after all expected words were issued");
    end
    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: dv/zcmp_expander_asserts.sv
// handshake assertions for the zcmp expander top level
`timescale 1ns/1ps

module zcmp_expander_asserts (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 issue_ack_i,
  input logic [31:0]          instr_o,
  input logic                 instr_valid_o,
  input logic                 illegal_o,
  input logic                 fetch_stall_o,
  input zcmp_pkg::seq_state_e seq_state_i
);
  import zcmp_pkg::*;

  reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> !instr_valid_o && !illegal_o && !fetch_stall_o)
    else $error("outputs active during reset");

  // back-pressure holds the word
  hold_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_o && !issue_ack_i |=> instr_valid_o && $stable(instr_o) && $stable(illegal_o))
    else $error("instruction changed without acknowledge");

  // more words of the operation follow
  stall_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_stall_o |=> instr_valid_o)
    else $error("fetch stall without a following instruction");

  illegal_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_o |-> !fetch_stall_o)
    else $error("illegal word is not the last of its operation");

  idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    seq_state_i == ST_IDLE |-> !illegal_o)
    else $error("illegal flag raised while the sequencer is idle");

endmodule

bind zcmp_expander zcmp_expander_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .issue_ack_i   (issue_ack_i),
  .instr_o       (instr_o),
  .instr_valid_o (instr_valid_o),
  .illegal_o     (illegal_o),
  .fetch_stall_o (fetch_stall_o),
  .seq_state_i   (u_sequencer.state_q)
);

// File: hdl/zcmp_expander.sv
// zcmp expander top, turns push/pop/move parcels into rv32i instruction streams
`timescale 1ns/1ps

module zcmp_expander (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [15:0] parcel_i,
  input  logic        parcel_valid_i,
  output logic        parcel_ready_o,
  input  logic        issue_ack_i,
  output logic [31:0] instr_o,
  output logic        instr_valid_o,
  output logic        illegal_o,
  output logic        fetch_stall_o
);
  import zcmp_pkg::*;

  logic        dec_valid;
  logic        dec_take;
  zcmp_op_e    dec_op;
  logic [3:0]  dec_count;
  logic [8:0]  dec_adj;
  logic [4:0]  dec_reg1;
  logic [4:0]  dec_reg2;
  logic [15:0] dec_parcel;

  logic        uop_valid;
  uop_kind_e   uop_kind;
  logic [4:0]  uop_rd;
  logic [4:0]  uop_rs1;
  logic [11:0] uop_imm;
  logic [15:0] uop_parcel;
  logic        uop_last;

  zcmp_decode u_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .parcel_i       (parcel_i),
    .parcel_valid_i (parcel_valid_i),
    .dec_take_i     (dec_take),
    .parcel_ready_o (parcel_ready_o),
    .dec_valid_o    (dec_valid),
    .dec_op_o       (dec_op),
    .dec_count_o    (dec_count),
    .dec_adj_o      (dec_adj),
    .dec_reg1_o     (dec_reg1),
    .dec_reg2_o     (dec_reg2),
    .dec_parcel_o   (dec_parcel)
  );

  zcmp_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dec_valid_i  (dec_valid),
    .dec_op_i     (dec_op),
    .dec_count_i  (dec_count),
    .dec_adj_i    (dec_adj),
    .dec_reg1_i   (dec_reg1),
    .dec_reg2_i   (dec_reg2),
    .dec_parcel_i (dec_parcel),
    .issue_ack_i  (issue_ack_i),
    .dec_take_o   (dec_take),
    .uop_valid_o  (uop_valid),
    .uop_kind_o   (uop_kind),
    .uop_rd_o     (uop_rd),
    .uop_rs1_o    (uop_rs1),
    .uop_imm_o    (uop_imm),
    .uop_parcel_o (uop_parcel),
    .uop_last_o   (uop_last)
  );

  zcmp_result u_result (
    .uop_kind_i   (uop_kind),
    .uop_rd_i     (uop_rd),
    .uop_rs1_i    (uop_rs1),
    .uop_imm_i    (uop_imm),
    .uop_parcel_i (uop_parcel),
    .instr_o      (instr_o),
    .illegal_o    (illegal_o)
  );

  assign instr_valid_o = uop_valid;
  assign fetch_stall_o = uop_valid && !uop_last;  // more words of this op follow

endmodule

// File: hdl/zcmp_result.sv
// rv32i encoder, turns the current micro-op into a 32-bit instruction word
`timescale 1ns/1ps

module zcmp_result (
  input  zcmp_pkg::uop_kind_e  uop_kind_i,
  input  logic [4:0]           uop_rd_i,
  input  logic [4:0]           uop_rs1_i,
  input  logic [11:0]          uop_imm_i,
  input  logic [15:0]          uop_parcel_i,
  output logic [31:0]          instr_o,
  output logic                 illegal_o
);
  import zcmp_pkg::*;

  logic [31:0] s_store;
  logic [31:0] i_load;
  logic [31:0] i_addi;
  logic [31:0] i_jalr;

  // store carries the data register in rs2, immediate split around it
  assign s_store = {
    uop_imm_i[11:5],
    uop_rd_i,
    uop_rs1_i,
    FUNCT3_W,
    uop_imm_i[4:0],
    OPC_STORE
  };

  assign i_load = {uop_imm_i, uop_rs1_i, FUNCT3_W, uop_rd_i, OPC_LOAD};
  assign i_addi = {uop_imm_i, uop_rs1_i, FUNCT3_ADDI, uop_rd_i, OPC_OP_IMM};
  assign i_jalr = {uop_imm_i, uop_rs1_i, FUNCT3_JALR, uop_rd_i, OPC_JALR};

  always_comb begin
    instr_o   = i_addi;
    illegal_o = 1'b0;
    unique case (uop_kind_i)
      UOP_STORE: begin
        instr_o = s_store;
      end
      UOP_LOAD: begin
        instr_o = i_load;
      end
      UOP_ADDI: begin
        instr_o = i_addi;
      end
      UOP_JALR: begin
        instr_o = i_jalr;
      end
      UOP_ILLEGAL: begin
        instr_o   = {16'h0000, uop_parcel_i};  // raw parcel for the trap
        illegal_o = 1'b1;
      end
      default: begin
        instr_o = i_addi;
      end
    endcase
  end

endmodule

// File: hdl/zcmp_sequencer.sv
// zcmp micro-op sequencer, steps one operation per issue acknowledge
`timescale 1ns/1ps

module zcmp_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 dec_valid_i,
  input  zcmp_pkg::zcmp_op_e   dec_op_i,
  input  logic [3:0]           dec_count_i,
  input  logic [8:0]           dec_adj_i,
  input  logic [4:0]           dec_reg1_i,
  input  logic [4:0]           dec_reg2_i,
  input  logic [15:0]          dec_parcel_i,
  input  logic                 issue_ack_i,
  output logic                 dec_take_o,
  output logic                 uop_valid_o,
  output zcmp_pkg::uop_kind_e  uop_kind_o,
  output logic [4:0]           uop_rd_o,
  output logic [4:0]           uop_rs1_o,
  output logic [11:0]          uop_imm_o,
  output logic [15:0]          uop_parcel_o,
  output logic                 uop_last_o
);
  import zcmp_pkg::*;

  // state names the word currently on the output
  seq_state_e  state_q, state_d;
  zcmp_op_e    op_q, op_d;
  logic [3:0]  idx_q, idx_d;  // list index of the current load/store
  logic [8:0]  adj_q, adj_d;
  logic [4:0]  reg2_q, reg2_d;
  uop_kind_e   kind_q, kind_d;
  logic [4:0]  rd_q, rd_d;
  logic [4:0]  rs1_q, rs1_d;
  logic [11:0] imm_q, imm_d;  // also the running stack offset
  logic [15:0] parcel_q, parcel_d;
  logic        last_q, last_d;
  logic        advance;
  logic        is_ret;
  logic [11:0] sp_imm;

  assign uop_valid_o = (state_q != ST_IDLE);
  assign advance     = uop_valid_o && issue_ack_i;
  assign dec_take_o  = dec_valid_i && (!uop_valid_o || (advance && last_q));

  assign is_ret = (op_q == OP_POPRET) || (op_q == OP_POPRETZ);
  assign sp_imm = (op_q == OP_PUSH) ? 12'd0 - {3'b000, adj_q} : {3'b000, adj_q};

  always_comb begin
    state_d  = state_q;
    op_d     = op_q;
    idx_d    = idx_q;
    adj_d    = adj_q;
    reg2_d   = reg2_q;
    kind_d   = kind_q;
    rd_d     = rd_q;
    rs1_d    = rs1_q;
    imm_d    = imm_q;
    parcel_d = parcel_q;
    last_d   = last_q;

    if (advance) begin
      unique case (state_q)
        ST_MEM: begin
          if (idx_q != 4'd0) begin
            idx_d = idx_q - 4'd1;
            rd_d  = rlist_reg(idx_q - 4'd1);
            imm_d = imm_q - 12'(WORD_BYTES);
          end else if (op_q == OP_POPRETZ) begin
            state_d = ST_ZERO;  // addi a0, x0, 0
            kind_d  = UOP_ADDI;
            rd_d    = REG_A0;
            rs1_d   = REG_ZERO;
            imm_d   = 12'd0;
          end else begin
            state_d = ST_SP;
            kind_d  = UOP_ADDI;
            rd_d    = REG_SP;
            rs1_d   = REG_SP;
            imm_d   = sp_imm;
            last_d  = !is_ret;
          end
        end
        ST_ZERO: begin
          state_d = ST_SP;
          rd_d    = REG_SP;
          rs1_d   = REG_SP;
          imm_d   = sp_imm;
        end
        ST_SP: begin
          if (is_ret) begin
            state_d = ST_RET;  // jalr x0, ra, 0
            kind_d  = UOP_JALR;
            rd_d    = REG_ZERO;
            rs1_d   = REG_RA;
            imm_d   = 12'd0;
            last_d  = 1'b1;
          end else begin
            state_d = ST_IDLE;
          end
        end
        ST_MOVE2: begin
          state_d = ST_LAST;
          last_d  = 1'b1;
          if (op_q == OP_MVSA01) begin
            rd_d  = reg2_q;
            rs1_d = REG_A1;
          end else begin
            rd_d  = REG_A1;
            rs1_d = reg2_q;
          end
        end
        default: state_d = ST_IDLE;  // ret or single word done
      endcase
    end

    // keeps illegal_o quiet while nothing is issued
    if (state_d == ST_IDLE) begin
      kind_d = UOP_ADDI;
    end

    if (dec_take_o) begin
      op_d     = dec_op_i;
      adj_d    = dec_adj_i;
      reg2_d   = dec_reg2_i;
      parcel_d = dec_parcel_i;
      idx_d    = dec_count_i - 4'd1;
      rd_d     = rlist_reg(dec_count_i - 4'd1);
      rs1_d    = REG_SP;
      imm_d    = 12'd0;
      last_d   = 1'b0;
      unique case (dec_op_i)
        OP_PUSH: begin
          state_d = ST_MEM;
          kind_d  = UOP_STORE;
          imm_d   = 12'd0 - 12'(WORD_BYTES);
        end
        OP_POP, OP_POPRETZ, OP_POPRET: begin
          state_d = ST_MEM;
          kind_d  = UOP_LOAD;
          imm_d   = {3'b000, dec_adj_i} - 12'(WORD_BYTES);  // top slot first
        end
        OP_MVSA01: begin
          state_d = ST_MOVE2;
          kind_d  = UOP_ADDI;
          rd_d    = dec_reg1_i;
          rs1_d   = REG_A0;
        end
        OP_MVA01S: begin
          state_d = ST_MOVE2;
          kind_d  = UOP_ADDI;
          rd_d    = REG_A0;
          rs1_d   = dec_reg1_i;
        end
        default: begin
          state_d = ST_LAST;
          kind_d  = UOP_ILLEGAL;
          last_d  = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      op_q    <= OP_ILLEGAL;
      idx_q   <= 4'd0;
      kind_q  <= UOP_ADDI;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      op_q    <= op_d;
      idx_q   <= idx_d;
      kind_q  <= kind_d;
      last_q  <= last_d;
    end
  end

  always_ff @(posedge clk_i) begin
    adj_q    <= adj_d;
    reg2_q   <= reg2_d;
    rd_q     <= rd_d;
    rs1_q    <= rs1_d;
    imm_q    <= imm_d;
    parcel_q <= parcel_d;
  end

  assign uop_kind_o   = kind_q;
  assign uop_rd_o     = rd_q;
  assign uop_rs1_o    = rs1_q;
  assign uop_imm_o    = imm_q;
  assign uop_parcel_o = parcel_q;
  assign uop_last_o   = last_q;

endmodule

// File: hdl/zcmp_decode.sv
// zcmp parcel decoder, checks legality and buffers one decoded operation
`timescale 1ns/1ps

module zcmp_decode (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [15:0]         parcel_i,
  input  logic                parcel_valid_i,
  input  logic                dec_take_i,
  output logic                parcel_ready_o,
  output logic                dec_valid_o,
  output zcmp_pkg::zcmp_op_e  dec_op_o,
  output logic [3:0]          dec_count_o,
  output logic [8:0]          dec_adj_o,
  output logic [4:0]          dec_reg1_o,
  output logic [4:0]          dec_reg2_o,
  output logic [15:0]         dec_parcel_o
);
  import zcmp_pkg::*;

  logic       is_zcmp;
  logic [3:0] rlist;
  logic [1:0] spimm;
  logic [3:0] count;
  logic [4:0] reg1;
  logic [4:0] reg2;
  zcmp_op_e   op;
  logic       accept;

  assign is_zcmp = (parcel_i[1:0] == ZCMP_QUADRANT) && (parcel_i[15:13] == ZCMP_FUNCT3);
  assign rlist   = parcel_i[7:4];
  assign spimm   = parcel_i[3:2];
  assign count   = rlist_count(rlist);
  assign reg1    = sreg_map(parcel_i[9:7]);
  assign reg2    = sreg_map(parcel_i[4:2]);

  always_comb begin
    op = OP_ILLEGAL;
    if (is_zcmp) begin
      if (parcel_i[12:10] == ZCMP_FN_MOVE) begin
        unique case (parcel_i[6:5])
          ZCMP_MV_SA01: op = OP_MVSA01;
          ZCMP_MV_A01S: op = OP_MVA01S;
          default:      op = OP_ILLEGAL;
        endcase
        // r1s == r2s is reserved
        if (parcel_i[9:7] == parcel_i[4:2]) begin
          op = OP_ILLEGAL;
        end
      end else begin
        unique case (parcel_i[12:8])
          ZCMP_FN_PUSH:    op = OP_PUSH;
          ZCMP_FN_POP:     op = OP_POP;
          ZCMP_FN_POPRETZ: op = OP_POPRETZ;
          ZCMP_FN_POPRET:  op = OP_POPRET;
          default:         op = OP_ILLEGAL;
        endcase
        if (rlist < RLIST_MIN) begin
          op = OP_ILLEGAL;  // reserved rlist
        end
      end
    end
  end

  // one entry, may refill in the cycle it is taken
  assign parcel_ready_o = !dec_valid_o || dec_take_i;
  assign accept         = parcel_valid_i && parcel_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
    end else if (accept) begin
      dec_valid_o <= 1'b1;
    end else if (dec_take_i) begin
      dec_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_op_o     <= op;
      dec_count_o  <= count;
      dec_adj_o    <= stack_adj(count, spimm);
      dec_reg1_o   <= reg1;
      dec_reg2_o   <= reg2;
      dec_parcel_o <= parcel_i;
    end
  end

endmodule

// File: hdl/zcmp_pkg.sv
// zcmp expander package with encodings, register numbers, enums and list helpers
package zcmp_pkg;

  // rv32i major opcodes and function codes
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  localparam logic [2:0] FUNCT3_W    = 3'b010;
  localparam logic [2:0] FUNCT3_ADDI = 3'b000;
  localparam logic [2:0] FUNCT3_JALR = 3'b000;

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;
  localparam logic [4:0] REG_A0   = 5'd10;
  localparam logic [4:0] REG_A1   = 5'd11;

  // parcel fields that mark zcmp
  localparam logic [1:0] ZCMP_QUADRANT = 2'b10;
  localparam logic [2:0] ZCMP_FUNCT3   = 3'b101;

  localparam logic [4:0] ZCMP_FN_PUSH    = 5'b11000;  // parcel[12:8]
  localparam logic [4:0] ZCMP_FN_POP     = 5'b11010;
  localparam logic [4:0] ZCMP_FN_POPRETZ = 5'b11100;
  localparam logic [4:0] ZCMP_FN_POPRET  = 5'b11110;
  localparam logic [2:0] ZCMP_FN_MOVE    = 3'b011;    // parcel[12:10]
  localparam logic [1:0] ZCMP_MV_SA01    = 2'b01;     // parcel[6:5]
  localparam logic [1:0] ZCMP_MV_A01S    = 2'b11;

  localparam int unsigned WORD_BYTES  = 4;
  localparam int unsigned STACK_ALIGN = 16;
  localparam logic [3:0]  RLIST_MIN   = 4'd4;
  localparam int unsigned MAX_REGS    = 13;

  typedef enum logic [2:0] {
    OP_PUSH, OP_POP, OP_POPRETZ, OP_POPRET, OP_MVSA01, OP_MVA01S, OP_ILLEGAL
  } zcmp_op_e;

  typedef enum logic [2:0] {
    UOP_STORE, UOP_LOAD, UOP_ADDI, UOP_JALR, UOP_ILLEGAL
  } uop_kind_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_MEM, ST_ZERO, ST_SP, ST_RET, ST_MOVE2, ST_LAST
  } seq_state_e;

  function automatic logic [3:0] rlist_count(input logic [3:0] rlist);
    if (rlist == 4'd15) return 4'(MAX_REGS);  // s10 and s11 come as a pair
    if (rlist < RLIST_MIN) return 4'd0;
    return rlist - 4'd3;
  endfunction

  // list index to register: ra, s0, s1, then s2..s11
  function automatic logic [4:0] rlist_reg(input logic [3:0] idx);
    case (idx)
      4'd0:    return REG_RA;
      4'd1:    return 5'd8;
      4'd2:    return 5'd9;
      default: return {1'b0, idx} + 5'd15;
    endcase
  endfunction

  function automatic logic [8:0] stack_adj(input logic [3:0] count, input logic [1:0] spimm);
    logic [8:0] bytes;
    logic [8:0] aligned;
    bytes   = 9'(count * WORD_BYTES);
    aligned = (bytes + 9'(STACK_ALIGN - 1)) & ~9'(STACK_ALIGN - 1);
    return aligned + 9'(spimm * STACK_ALIGN);
  endfunction

  // sreg field: 0,1 -> s0,s1 and 2..7 -> s2..s7
  function automatic logic [4:0] sreg_map(input logic [2:0] field);
    if (field[2:1] == 2'b00) return {4'b0100, field[0]};
    return {2'b10, field};
  endfunction

endpackage
